// ==== filelist.f ====
src/chess_board_pkg.sv
src/eval_pkg.sv
src/piece_square_scorer.sv
src/mobility_material_scorer.sv
src/eval_combiner.sv
src/board_evaluator.sv
dv/board_evaluator_tb.sv

// ==== dv/board_evaluator_tb.sv ====
`timescale 1ns/1ps

module board_evaluator_tb;
   import chess_board_pkg::*;
   import eval_pkg::*;

   localparam int POP_WEIGHT  = 10;
   localparam int NUM_HAND    = 10;
   localparam int NUM_RANDOM  = 20;
   localparam int NUM_ENTRIES = NUM_HAND + NUM_RANDOM;
   localparam int TIMEOUT     = NUM_ENTRIES * 8 + 50;

   typedef struct packed
   {
      eval_request_t req;
      logic [7:0]    ready;  // res_ready per cycle while this entry is offered
      eval_result_t  exp;
   } entry_t;

   logic          clk;
   logic          reset;
   logic          req_valid;
   eval_request_t req;
   logic          req_ready;
   logic          res_valid;
   eval_result_t  res;
   logic          res_ready;

   entry_t        stim_table [NUM_ENTRIES];
   int            num_built;
   logic [31:0]   lcg_state;
   int            cycle;
   int            stalls;
   int            accepted_count;
   int            results_seen;
   int            pending_idx [$];
   int            pending_cycle [$];
   int            pending_stalls [$];
   logic          held;
   eval_result_t  held_res;
   logic          accepted;
   logic [2:0]    phase;

   board_evaluator #(.POP_WEIGHT(POP_WEIGHT)) DUT
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .res_valid (res_valid),
      .res       (res),
      .res_ready (res_ready)
   );

   always #5 clk = ~clk;

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_score(string name, score_t got, score_t exp);
      if (got !== exp)
         report_failure($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         report_failure($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic verify_result(eval_result_t got, eval_result_t exp);
      check_score("res.eval", got.eval, exp.eval);
      check_score("res.material", got.material, exp.material);
      check_flag("res.insufficient_material", got.insufficient_material,
                 exp.insufficient_material);
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic score_t piece_worth(logic [3:0] code);
      score_t v;
      case (code[2:0])
         3'd1: v = VALUE_PAWN;
         3'd2: v = VALUE_KNIGHT;
         3'd3: v = VALUE_BISHOP;
         3'd4: v = VALUE_ROOK;
         3'd5: v = VALUE_QUEEN;
         3'd6: v = VALUE_KING;
         default: v = 0;
      endcase
      return code[3] ? -v : v;
   endfunction

   function automatic score_t placement_bonus(logic [3:0] code, int sq);
      int rank;
      int file;
      score_t b;
      rank = sq / 8;
      file = sq % 8;
      b = 0;
      if (code[2:0] == 3'd1)
         b = code[3] ? 5 * (6 - rank) : 5 * (rank - 1);  // Steps forward from the home rank
      else if ((code[2:0] == 3'd2 || code[2:0] == 3'd3) &&
               rank >= 2 && rank <= 5 && file >= 2 && file <= 5)
         b = 10;
      return code[3] ? -b : b;
   endfunction

   function automatic int material_class(logic [2:0] kind);
      if (kind == 3'd1 || kind == 3'd4 || kind == 3'd5)
         return 3;
      else if (kind == 3'd2 || kind == 3'd3)
         return 1;
      return 0;
   endfunction

   function automatic eval_result_t expected_result(eval_request_t r);
      eval_result_t e;
      score_t       positional;
      score_t       mobility;
      int           white_class;
      int           black_class;
      logic [3:0]   code;
      e = '0;
      positional = 0;
      white_class = 0;
      black_class = 0;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         code = r.board[sq];
         e.material = e.material + piece_worth(code);
         positional = positional + piece_worth(code) + placement_bonus(code, sq);
         if (code[3])
            black_class = black_class + material_class(code[2:0]);
         else
            white_class = white_class + material_class(code[2:0]);
      end
      mobility = (int'(r.white_pop) - int'(r.black_pop)) * POP_WEIGHT;
      if (r.use_random_bit && r.random_bit)
         mobility = mobility + (r.white_to_move ? 1 : -1);
      e.insufficient_material = (white_class == 0 && black_class <= 1) ||
                                (white_class <= 1 && black_class == 0);
      e.eval = e.insufficient_material ? 0 : positional + mobility;
      return e;
   endfunction

   // Kings on e1 and e8
   function automatic board_t kings_only();
      board_t b;
      b = '0;
      b[4] = 4'd6;
      b[60] = 4'd14;
      return b;
   endfunction

   function automatic board_t start_position();
      board_t     b;
      logic [2:0] back [8];
      back = '{3'd4, 3'd2, 3'd3, 3'd5, 3'd6, 3'd3, 3'd2, 3'd4};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f] = {1'b0, back[f]};
         b[8 + f] = 4'd1;
         b[48 + f] = 4'd9;
         b[56 + f] = {1'b1, back[f]};
      end
      return b;
   endfunction

   task automatic add_entry(board_t b, logic wtm, logic use_rb, logic rb, pop_t wp, pop_t bp,
                            logic [7:0] ready);
      entry_t e;
      e.req = {b, wtm, use_rb, rb, wp, bp};
      e.ready = ready;
      e.exp = expected_result(e.req);
      stim_table[num_built] = e;
      num_built = num_built + 1;
   endtask

   task automatic build_table();
      board_t      b;
      logic [31:0] rnd;
      add_entry(start_position(), 1, 0, 0, 20, 20, 8'hff);
      add_entry(start_position(), 1, 0, 0, 22, 20, 8'hff);
      add_entry(kings_only(), 1, 0, 0, 5, 3, 8'hff);
      b = kings_only();
      b[18] = 4'd2;  // White knight on c3
      add_entry(b, 1, 0, 0, 7, 2, 8'hff);
      b = kings_only();
      b[12] = 4'd1;
      add_entry(b, 0, 0, 0, 4, 2, 8'hff);
      add_entry(start_position(), 1, 1, 1, 20, 20, 8'hff);
      add_entry(start_position(), 0, 1, 1, 20, 20, 8'hff);
      add_entry(start_position(), 1, 0, 1, 20, 20, 8'hff);
      b = kings_only();
      b[48] = 4'd1;  // White pawn on a7
      add_entry(b, 1, 0, 0, 0, 0, 8'hff);
      b = kings_only();
      b[0] = 4'd4;
      b[56] = 4'd12;
      b[35] = 4'd10;  // Black knight on d5
      add_entry(b, 1, 0, 0, 0, 0, 8'hff);
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         for (int sq = 0; sq < NUM_SQUARES; sq++)
         begin
            rnd = next_random();
            b[sq] = rnd[16] ? 4'd0 : {rnd[20], 3'(1 + rnd[27:24] % 6)};
         end
         rnd = next_random();
         add_entry(b, rnd[16], rnd[17], rnd[18], rnd[24:19], rnd[30:25],
                   rnd[15:8] | 8'h11);
      end
      // Anchor the model against hand-worked positions
      check_score("model start eval", stim_table[0].exp.eval, 0);
      check_score("model start pop eval", stim_table[1].exp.eval, 20);
      check_score("model knight material", stim_table[3].exp.material, 300);
      check_score("model pawn eval", stim_table[8].exp.eval, 125);
      check_score("model knight eval", stim_table[9].exp.eval, -310);
   endtask

   always @(posedge clk)
   begin : monitor
      int idx;
      int latency;
      cycle = cycle + 1;
      if (cycle >= TIMEOUT)
         report_failure("Run timed out before all results arrived");
      if (!reset)
      begin
         if (held)
            verify_result(res, held_res);  // Output must not move while stalled
         held = res_valid && !res_ready;
         check_flag("req_ready", req_ready, !held);
         if (held)
         begin
            held_res = res;
            stalls = stalls + 1;
         end
         if (res_valid && res_ready)
         begin
            if (pending_idx.size() == 0)
               report_failure("A result arrived with no request outstanding");
            idx = pending_idx.pop_front();
            latency = cycle - pending_cycle.pop_front() - (stalls - pending_stalls.pop_front());
            if (latency != 4)
               report_failure($sformatf("Entry %0d took %0d unstalled cycles instead of 4",
                                        idx, latency));
            verify_result(res, stim_table[idx].exp);
            results_seen = results_seen + 1;
         end
         if (req_valid && req_ready)
         begin
            pending_idx.push_back(accepted_count);
            pending_cycle.push_back(cycle);
            pending_stalls.push_back(stalls);
            accepted_count = accepted_count + 1;
         end
      end
   end

   initial
   begin
      clk = 0;
      reset = 1;
      req_valid = 0;
      req = '0;
      res_ready = 1;
      lcg_state = 42;
      num_built = 0;
      cycle = 0;
      stalls = 0;
      accepted_count = 0;
      results_seen = 0;
      held = 0;
      held_res = '0;
      phase = '0;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      reset = 0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         req_valid = 1;
         req = stim_table[i].req;
         accepted = 0;
         while (!accepted)
         begin
            res_ready = stim_table[i].ready[phase];
            @(posedge clk);
            accepted = req_ready;
            #1;
            phase = phase + 1;
         end
      end
      req_valid = 0;
      res_ready = 1;
      wait (results_seen == NUM_ENTRIES);
      @(posedge clk);
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== src/board_evaluator.sv ====
`timescale 1ns/1ps

module board_evaluator
#(
   parameter int POP_WEIGHT = 10
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req_valid,
   input  eval_pkg::eval_request_t req,
   output logic                    req_ready,
   output logic                    res_valid,
   output eval_pkg::eval_result_t  res,
   input  logic                    res_ready
);
   import eval_pkg::*;

   pss_out_t pss;
   mob_out_t mob;
   logic     advance;

   assign req_ready = advance;  // A new board enters whenever the pipeline moves

   piece_square_scorer u_piece_square_scorer
   (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .board   (req.board),
      .pss     (pss)
   );

   mobility_material_scorer
   #(
      .POP_WEIGHT (POP_WEIGHT)
   )
   u_mobility_material_scorer
   (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .req     (req),
      .mob     (mob)
   );

   eval_combiner u_eval_combiner
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .res_ready (res_ready),
      .pss       (pss),
      .mob       (mob),
      .advance   (advance),
      .res_valid (res_valid),
      .res       (res)
   );

endmodule

// ==== src/eval_combiner.sv ====
`timescale 1ns/1ps

module eval_combiner
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req_valid,
   input  logic                   res_ready,
   input  eval_pkg::pss_out_t     pss,
   input  eval_pkg::mob_out_t     mob,
   output logic                   advance,
   output logic                   res_valid,
   output eval_pkg::eval_result_t res
);
   import eval_pkg::*;

   localparam int DEPTH = 4;

   logic [DEPTH-1:0] valid_chain;  // Stages 1 to 3, then the output register
   logic             stage3_valid;
   score_t           eval_d;

   assign res_valid    = valid_chain[DEPTH-1];
   assign stage3_valid = valid_chain[DEPTH-2];

   // Every stage holds while a finished result waits for the consumer
   assign advance = ~res_valid | res_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_chain <= '0;
      end
      else if (advance)
      begin
         valid_chain <= {valid_chain[DEPTH-2:0], req_valid};
      end
   end

   // A drawn material class scores as level
   always_comb
   begin
      if (mob.insufficient)
         eval_d = '0;
      else
         eval_d = pss.positional + mob.mobility;
   end

   always_ff @(posedge clk)
   begin
      if (advance && stage3_valid)
      begin
         res.eval                  <= eval_d;
         res.material              <= pss.material;
         res.insufficient_material <= mob.insufficient;
      end
   end

endmodule

// ==== src/mobility_material_scorer.sv ====
`timescale 1ns/1ps

module mobility_material_scorer
#(
   parameter int POP_WEIGHT = 10
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    advance,
   input  eval_pkg::eval_request_t req,
   output eval_pkg::mob_out_t      mob
);
   import chess_board_pkg::*;
   import eval_pkg::*;

   mob_s1_t    s1;
   mob_s2_t    s2;
   rand_term_t rand_term_d;
   logic [1:0] s1_white_class [NUM_SQUARES];
   logic [1:0] s1_black_class [NUM_SQUARES];
   class_sum_t white_class_d;
   class_sum_t black_class_d;

   // Tie-break bit counts for the side to move
   always_comb
   begin
      if (!req.use_random_bit)
         rand_term_d = '0;
      else if (req.white_to_move)
         rand_term_d = rand_term_t'({1'b0, req.random_bit});
      else
         rand_term_d = -rand_term_t'({1'b0, req.random_bit});
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         s1.white_pop <= req.white_pop;
         s1.black_pop <= req.black_pop;
         s1.rand_term <= rand_term_d;
         for (int sq = 0; sq < NUM_SQUARES; sq++)
         begin
            s1_white_class[sq] <= req.board[sq].fields.black ?
                                  2'd0 : class_weight(req.board[sq].fields.kind);
            s1_black_class[sq] <= req.board[sq].fields.black ?
                                  class_weight(req.board[sq].fields.kind) : 2'd0;
         end
      end
   end

   always_comb
   begin
      white_class_d = '0;
      black_class_d = '0;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         white_class_d = white_class_d + class_sum_t'(s1_white_class[sq]);
         black_class_d = black_class_d + class_sum_t'(s1_black_class[sq]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         s2.white_score <= score_t'(s1.white_pop) * POP_WEIGHT;
         s2.black_score <= score_t'(s1.black_pop) * POP_WEIGHT;
         s2.rand_term   <= s1.rand_term;
         s2.white_class <= white_class_d;
         s2.black_class <= black_class_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mob <= '0;
      end
      else if (advance)
      begin
         mob.mobility     <= s2.white_score - s2.black_score + score_t'(s2.rand_term);
         mob.insufficient <= (s2.white_class == 0 && s2.black_class <= 1) ||
                             (s2.white_class <= 1 && s2.black_class == 0);
      end
   end

endmodule

// ==== src/piece_square_scorer.sv ====
`timescale 1ns/1ps

module piece_square_scorer
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    advance,
   input  chess_board_pkg::board_t board,
   output eval_pkg::pss_out_t      pss
);
   import chess_board_pkg::*;
   import eval_pkg::*;

   piece_score_t s1_value [NUM_SQUARES];  // Signed material per square
   piece_score_t s1_total [NUM_SQUARES];  // Material plus square bonus
   score_t       row_value_d [NUM_RANKS];
   score_t       row_total_d [NUM_RANKS];
   score_t       s2_row_value [NUM_RANKS];
   score_t       s2_row_total [NUM_RANKS];
   score_t       material_d;
   score_t       positional_d;

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         for (int sq = 0; sq < NUM_SQUARES; sq++)
         begin
            s1_value[sq] <= piece_value(board[sq]);
            s1_total[sq] <= piece_value(board[sq]) + square_bonus(board[sq], square_t'(sq));
         end
      end
   end

   // One partial per rank for each quantity
   always_comb
   begin
      for (int r = 0; r < NUM_RANKS; r++)
      begin
         row_value_d[r] = '0;
         row_total_d[r] = '0;
         for (int f = 0; f < NUM_FILES; f++)
         begin
            row_value_d[r] = row_value_d[r] + score_t'(s1_value[r * NUM_FILES + f]);
            row_total_d[r] = row_total_d[r] + score_t'(s1_total[r * NUM_FILES + f]);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         s2_row_value <= row_value_d;
         s2_row_total <= row_total_d;
      end
   end

   always_comb
   begin
      material_d   = '0;
      positional_d = '0;
      for (int r = 0; r < NUM_RANKS; r++)
      begin
         material_d   = material_d + s2_row_value[r];
         positional_d = positional_d + s2_row_total[r];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pss <= '0;
      end
      else if (advance)
      begin
         pss.material   <= material_d;
         pss.positional <= positional_d;  // Already holds the material term
      end
   end

endmodule

// ==== src/eval_pkg.sv ====
package eval_pkg;
   import chess_board_pkg::*;

   typedef logic signed [31:0] score_t;
   typedef logic signed [15:0] piece_score_t;  // Enough for a king plus any bonus
   typedef logic [5:0]         pop_t;
   typedef logic [7:0]         class_sum_t;
   typedef logic signed [1:0]  rand_term_t;

   localparam piece_score_t VALUE_PAWN   = 16'sd100;
   localparam piece_score_t VALUE_KNIGHT = 16'sd300;
   localparam piece_score_t VALUE_BISHOP = 16'sd310;
   localparam piece_score_t VALUE_ROOK   = 16'sd500;
   localparam piece_score_t VALUE_QUEEN  = 16'sd900;
   localparam piece_score_t VALUE_KING   = 16'sd20000;

   // Indexed by raw code, the black half carries negated values
   localparam piece_score_t PIECE_VALUE [16] = '{
      '0, VALUE_PAWN, VALUE_KNIGHT, VALUE_BISHOP, VALUE_ROOK, VALUE_QUEEN, VALUE_KING, '0,
      '0, -VALUE_PAWN, -VALUE_KNIGHT, -VALUE_BISHOP, -VALUE_ROOK, -VALUE_QUEEN, -VALUE_KING, '0
   };

   localparam int PAWN_STEP_BONUS = 5;
   localparam int CENTRE_BONUS    = 10;
   localparam int CENTRE_LO       = 2;
   localparam int CENTRE_HI       = 5;

   typedef struct packed
   {
      board_t board;
      logic   white_to_move;
      logic   use_random_bit;
      logic   random_bit;
      pop_t   white_pop;
      pop_t   black_pop;
   } eval_request_t;

   typedef struct packed
   {
      score_t eval;
      score_t material;
      logic   insufficient_material;
   } eval_result_t;

   typedef struct packed
   {
      score_t material;
      score_t positional;
   } pss_out_t;

   typedef struct packed
   {
      score_t mobility;
      logic   insufficient;
   } mob_out_t;

   typedef struct packed
   {
      pop_t       white_pop;
      pop_t       black_pop;
      rand_term_t rand_term;
   } mob_s1_t;

   typedef struct packed
   {
      score_t     white_score;
      score_t     black_score;
      rand_term_t rand_term;
      class_sum_t white_class;
      class_sum_t black_class;
   } mob_s2_t;

   function automatic piece_score_t piece_value(piece_u p);
      return PIECE_VALUE[p.raw_code];
   endfunction

   function automatic piece_score_t square_bonus(piece_u p, square_t sq);
      int           rank;
      int           file;
      piece_score_t bonus;
      rank  = int'(square_rank(sq));
      file  = int'(square_file(sq));
      bonus = '0;
      case (p.fields.kind)
         PIECE_PAWN:
            if (p.fields.black)
               bonus = piece_score_t'(PAWN_STEP_BONUS * (6 - rank));
            else
               bonus = piece_score_t'(PAWN_STEP_BONUS * (rank - 1));
         PIECE_KNIGHT, PIECE_BISHOP:
            if (rank >= CENTRE_LO && rank <= CENTRE_HI && file >= CENTRE_LO && file <= CENTRE_HI)
               bonus = piece_score_t'(CENTRE_BONUS);
         default:
            bonus = '0;
      endcase
      if (p.fields.black)
         bonus = -bonus;
      return bonus;
   endfunction

   // Weight toward the insufficient material test
   function automatic logic [1:0] class_weight(piece_kind_e kind);
      case (kind)
         PIECE_PAWN, PIECE_ROOK, PIECE_QUEEN: return 2'd3;
         PIECE_KNIGHT, PIECE_BISHOP:          return 2'd1;
         default:                             return 2'd0;
      endcase
   endfunction

endpackage

// ==== src/chess_board_pkg.sv ====
package chess_board_pkg;

   localparam int NUM_SQUARES = 64;
   localparam int NUM_RANKS   = 8;
   localparam int NUM_FILES   = 8;

   typedef enum logic [2:0]
   {
      PIECE_EMPTY  = 3'd0,
      PIECE_PAWN   = 3'd1,
      PIECE_KNIGHT = 3'd2,
      PIECE_BISHOP = 3'd3,
      PIECE_ROOK   = 3'd4,
      PIECE_QUEEN  = 3'd5,
      PIECE_KING   = 3'd6
   } piece_kind_e;  // Code 7 is unused and reads as empty

   // One square of the board, seen either as a lookup code or as colour and kind
   typedef union packed
   {
      logic [3:0] raw_code;
      struct packed
      {
         logic        black;
         piece_kind_e kind;
      } fields;
   } piece_u;

   typedef piece_u [NUM_SQUARES-1:0] board_t;  // Index is rank * 8 + file

   typedef logic [5:0] square_t;
   typedef logic [2:0] coord_t;

   // Rank 0 is the White back rank
   function automatic coord_t square_rank(square_t sq);
      return sq[5:3];
   endfunction

   function automatic coord_t square_file(square_t sq);
      return sq[2:0];
   endfunction

endpackage
